// File: verilog/ad9866_pkg.sv
/*
  AD9866 codec port definitions
  Sample, nibble, gain and command types shared by the codec
  port blocks, plus the gain command addresses and the receive
  level thresholds.
*/

`default_nettype none

package ad9866_pkg;

  // Codec sample as two's complement
  typedef logic [11:0] sample_t;

  // One word on the 6-bit codec TX or RX bus
  typedef logic [5:0] nibble_t;

  // PGA gain code
  typedef logic [5:0] gain_t;

  // Command bus fields
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // Gain command addresses
  localparam cmd_addr_t ADDR_RX_GAIN = 6'h0a;
  localparam cmd_addr_t ADDR_TX_GAIN = 6'h0e;

  // RX gain loaded by reset
  localparam gain_t GAIN_RX_RESET = 6'h1f;

  // Full scale samples, either one counts as a clip
  localparam sample_t CLIP_POS = 12'h7ff;
  localparam sample_t CLIP_NEG = 12'h800;

  // Top three bits of a sample at a healthy level,
  // roughly 3/4 of full scale in either direction
  localparam logic [2:0] GOOD_POS = 3'b011;
  localparam logic [2:0] GOOD_NEG = 3'b100;

endpackage

`default_nettype wire

// File: verilog/gain_control.sv
/*
  Gain control
  Decodes the RX and TX gain commands, picks the gain the PGA
  should run at and flags a pending fast gain update until the
  transmit side has sent it in a gain frame.
*/

`timescale 1ns/1ps
`default_nettype none

module gain_control (
  input  logic                  clk,
  input  logic                  rxclrstatus,
  input  ad9866_pkg::cmd_addr_t cmd_addr,
  input  ad9866_pkg::cmd_data_t cmd_data,
  input  logic                  cmd_rqst,
  input  logic                  tx_en,
  input  logic                  cw_on,
  input  logic                  gain_taken,
  output logic                  cmd_ack,
  output ad9866_pkg::gain_t     gain,
  output logic                  gain_update
);

  ad9866_pkg::gain_t rx_gain;
  ad9866_pkg::gain_t tx_gain;
  logic              tx_gain_en;
  logic              tx_gain_active;
  ad9866_pkg::gain_t gain_next;

  // Bit 6 passes the code as is, bit 5 inverts it,
  // otherwise the low five bits get a leading one
  function automatic ad9866_pkg::gain_t decode_gain(input logic [6:0] field);
    ad9866_pkg::gain_t code;
    if (field[6]) begin
      code = field[5:0];
    end else if (field[5]) begin
      code = ~field[5:0];
    end else begin
      code = {1'b1, field[4:0]};
    end
    return code;
  endfunction

  // Command decode
  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rx_gain    <= ad9866_pkg::GAIN_RX_RESET;
      tx_gain    <= '0;
      tx_gain_en <= 1'b0;
      cmd_ack    <= 1'b0;
    end else begin
      cmd_ack <= cmd_rqst;
      if (cmd_rqst) begin
        case (cmd_addr)
          ad9866_pkg::ADDR_RX_GAIN: begin
            rx_gain <= decode_gain(cmd_data[6:0]);
          end
          ad9866_pkg::ADDR_TX_GAIN: begin
            tx_gain    <= decode_gain(cmd_data[14:8]);
            tx_gain_en <= cmd_data[15];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Gain selection, first matching rule wins
  always_comb begin
    tx_gain_active = tx_en & tx_gain_en;
    gain_next      = gain;
    if ((rx_gain != gain) && !tx_gain_active) begin
      gain_next = rx_gain;
    end else if ((tx_gain != gain) && tx_gain_active) begin
      gain_next = tx_gain;
    end else if ((tx_gain != gain) && cw_on) begin
      // Keyed CW with TX gain off runs the PGA at minimum
      gain_next = '0;
    end
  end

  // A new gain outranks a frame that takes the old one
  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      gain        <= '0;
      gain_update <= 1'b0;
    end else begin
      gain        <= gain_next;
      gain_update <= (gain_next != gain) | (gain_update & ~gain_taken);
    end
  end

  // Host issues single cycle requests, so acks never merge
  a_cmd_ack_single: assert property (
    @(posedge clk) disable iff (rxclrstatus) cmd_ack |=> !cmd_ack
  );

endmodule

`default_nettype wire

// File: verilog/tx_serializer.sv
/*
  Transmit serializer
  Splits each 12-bit sample into a high and a low nibble for the
  codec TX bus. A pending gain update replaces the high nibble of
  a frame, marked by pga5, and that frame carries no txsync.
*/

`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
  input  logic                clk,
  input  logic                rxclrstatus,
  input  ad9866_pkg::sample_t tx_data,
  input  logic                tx_en,
  input  ad9866_pkg::gain_t   gain,
  input  logic                gain_update,
  output logic                tx_strobe,
  output logic                gain_taken,
  output ad9866_pkg::nibble_t ad9866_tx,
  output logic                ad9866_txsync,
  output logic                ad9866_txquiet_n,
  output logic                ad9866_pga5
);

  logic                load_phase;
  logic                tx_en_d1;
  ad9866_pkg::sample_t frame_word;
  logic                frame_gain;
  logic                frame_en;

  assign tx_strobe        = load_phase & tx_en_d1;
  assign gain_taken       = load_phase & gain_update;
  assign ad9866_txquiet_n = tx_en_d1;

  // Frame word, loaded once per sample period
  always_ff @(posedge clk) begin
    if (load_phase) begin
      if (gain_update) begin
        frame_word <= {gain, tx_data[5:0]};
      end else begin
        frame_word <= tx_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      load_phase    <= 1'b0;
      tx_en_d1      <= 1'b0;
      frame_gain    <= 1'b0;
      frame_en      <= 1'b0;
      ad9866_tx     <= '0;
      ad9866_txsync <= 1'b0;
      ad9866_pga5   <= 1'b0;
    end else begin
      load_phase <= ~load_phase;
      tx_en_d1   <= tx_en;
      if (load_phase) begin
        frame_gain <= gain_update;
        frame_en   <= tx_en_d1;
        // Low nibble of the frame in flight
        ad9866_tx     <= frame_en ? frame_word[5:0] : '0;
        ad9866_txsync <= frame_en & ~frame_gain;
        ad9866_pga5   <= 1'b0;
      end else begin
        // High nibble, gain frames go out even when idle
        ad9866_tx     <= (frame_en | frame_gain) ? frame_word[11:6] : '0;
        ad9866_txsync <= 1'b0;
        ad9866_pga5   <= frame_gain;
      end
    end
  end

  // Codec would latch a gain nibble as sample data otherwise,
  // so the low nibble after a pga5 nibble carries no txsync
  a_sync_pga5_excl: assert property (
    @(posedge clk) disable iff (rxclrstatus) ad9866_pga5 |=> !ad9866_txsync
  );

endmodule

`default_nettype wire

// File: verilog/rx_deserializer.sv
/*
  Receive deserializer
  Captures the codec RX bus and rxsync, joins the nibble before
  the sync nibble with the sync nibble into a 12-bit sample and
  presents it with a one-cycle strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module rx_deserializer (
  input  logic                clk,
  input  logic                rxclrstatus,
  input  ad9866_pkg::nibble_t ad9866_rx,
  input  logic                ad9866_rxsync,
  output ad9866_pkg::sample_t rx_data,
  output logic                rx_strobe
);

  ad9866_pkg::nibble_t rx_d1;
  ad9866_pkg::nibble_t rx_d2;
  logic                rxsync_d1;
  ad9866_pkg::sample_t rx_word;
  logic                word_valid;

  // Data path, high nibble arrives first
  always_ff @(posedge clk) begin
    rx_d1 <= ad9866_rx;
    rx_d2 <= rx_d1;
    if (rxsync_d1) begin
      rx_word <= {rx_d2, rx_d1};
    end
    if (word_valid) begin
      rx_data <= rx_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rxsync_d1  <= 1'b0;
      word_valid <= 1'b0;
      rx_strobe  <= 1'b0;
    end else begin
      rxsync_d1  <= ad9866_rxsync;
      word_valid <= rxsync_d1;
      rx_strobe  <= word_valid;
    end
  end

  // Codec marks every second nibble only
  a_rx_strobe_gap: assert property (
    @(posedge clk) disable iff (rxclrstatus) rx_strobe |=> !rx_strobe
  );

endmodule

`default_nettype wire

// File: verilog/level_monitor.sv
/*
  Receive level monitor
  Sticky flags for received samples that hit full scale and for
  samples in the good level band. Only reset clears them.
*/

`timescale 1ns/1ps
`default_nettype none

module level_monitor (
  input  logic                clk,
  input  logic                rxclrstatus,
  input  ad9866_pkg::sample_t rx_data,
  input  logic                rx_strobe,
  output logic                rxclip,
  output logic                rxgoodlvl
);

  logic clip_hit;
  logic good_hit;

  assign clip_hit = (rx_data == ad9866_pkg::CLIP_POS) ||
                    (rx_data == ad9866_pkg::CLIP_NEG);

  // Top three bits give the level band
  assign good_hit = (rx_data[11:9] == ad9866_pkg::GOOD_POS) ||
                    (rx_data[11:9] == ad9866_pkg::GOOD_NEG);

  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rxclip    <= 1'b0;
      rxgoodlvl <= 1'b0;
    end else if (rx_strobe) begin
      if (clip_hit) begin
        rxclip <= 1'b1;
      end
      if (good_hit) begin
        rxgoodlvl <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ad9866_port.sv
/*
  AD9866 full duplex codec port
  Host side sample, command and status signals on one side, the
  codec TX and RX nibble buses on the other. Runs at nibble rate
  with fast PGA gain updates sent in the TX stream.
*/

`timescale 1ns/1ps
`default_nettype none

module ad9866_port (
  input  logic                  clk,
  input  logic                  rxclrstatus,

  // Host transmit
  input  ad9866_pkg::sample_t   tx_data,
  input  logic                  tx_en,
  output logic                  tx_strobe,
  input  logic                  cw_on,

  // Host receive and status
  output ad9866_pkg::sample_t   rx_data,
  output logic                  rx_strobe,
  output logic                  rxclip,
  output logic                  rxgoodlvl,

  // Command bus
  input  ad9866_pkg::cmd_addr_t cmd_addr,
  input  ad9866_pkg::cmd_data_t cmd_data,
  input  logic                  cmd_rqst,
  output logic                  cmd_ack,

  // Codec pins
  output ad9866_pkg::nibble_t   ad9866_tx,
  output logic                  ad9866_txsync,
  output logic                  ad9866_txquiet_n,
  output logic                  ad9866_pga5,
  output logic                  ad9866_mode,
  input  ad9866_pkg::nibble_t   ad9866_rx,
  input  logic                  ad9866_rxsync
);

  ad9866_pkg::gain_t gain;
  logic              gain_update;
  logic              gain_taken;

  // Full duplex only
  assign ad9866_mode = 1'b1;

  gain_control i_gain_control (
    .clk         (clk),
    .rxclrstatus (rxclrstatus),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .cmd_rqst    (cmd_rqst),
    .tx_en       (tx_en),
    .cw_on       (cw_on),
    .gain_taken  (gain_taken),
    .cmd_ack     (cmd_ack),
    .gain        (gain),
    .gain_update (gain_update)
  );

  tx_serializer i_tx_serializer (
    .clk              (clk),
    .rxclrstatus      (rxclrstatus),
    .tx_data          (tx_data),
    .tx_en            (tx_en),
    .gain             (gain),
    .gain_update      (gain_update),
    .tx_strobe        (tx_strobe),
    .gain_taken       (gain_taken),
    .ad9866_tx        (ad9866_tx),
    .ad9866_txsync    (ad9866_txsync),
    .ad9866_txquiet_n (ad9866_txquiet_n),
    .ad9866_pga5      (ad9866_pga5)
  );

  rx_deserializer i_rx_deserializer (
    .clk           (clk),
    .rxclrstatus   (rxclrstatus),
    .ad9866_rx     (ad9866_rx),
    .ad9866_rxsync (ad9866_rxsync),
    .rx_data       (rx_data),
    .rx_strobe     (rx_strobe)
  );

  level_monitor i_level_monitor (
    .clk         (clk),
    .rxclrstatus (rxclrstatus),
    .rx_data     (rx_data),
    .rx_strobe   (rx_strobe),
    .rxclip      (rxclip),
    .rxgoodlvl   (rxgoodlvl)
  );

endmodule

`default_nettype wire

// File: bench/tb_ad9866_port.sv
/*
  Testbench for the AD9866 codec port
  Random host samples, gain commands and codec RX words from a fixed
  seed. A cycle model of the framing, gain and level rules predicts
  every output, which is compared at the falling clock edge.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ad9866_port;

  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 10;
  localparam int FRAME_CYCLES     = 200;
  localparam int GAIN_CYCLES      = 400;
  localparam int SELECT_CYCLES    = 400;
  localparam int MID_RESET_CYCLES = 4;
  localparam int TAIL_CYCLES      = 200;
  localparam int TOTAL_CYCLES     = RESET_CYCLES + FRAME_CYCLES + GAIN_CYCLES +
                                    SELECT_CYCLES + MID_RESET_CYCLES + TAIL_CYCLES;
  localparam int TIMEOUT_NS       = TOTAL_CYCLES * CLK_PERIOD + 2000;

  localparam int MODE_RESET  = 0;
  localparam int MODE_FRAME  = 1;
  localparam int MODE_GAIN   = 2;
  localparam int MODE_SELECT = 3;

  logic                  clk = 1'b0;
  logic                  rxclrstatus;
  ad9866_pkg::sample_t   tx_data;
  logic                  tx_en;
  logic                  tx_strobe;
  logic                  cw_on;
  ad9866_pkg::sample_t   rx_data;
  logic                  rx_strobe;
  logic                  rxclip;
  logic                  rxgoodlvl;
  ad9866_pkg::cmd_addr_t cmd_addr;
  ad9866_pkg::cmd_data_t cmd_data;
  logic                  cmd_rqst;
  logic                  cmd_ack;
  ad9866_pkg::nibble_t   ad9866_tx;
  logic                  ad9866_txsync;
  logic                  ad9866_txquiet_n;
  logic                  ad9866_pga5;
  logic                  ad9866_mode;
  ad9866_pkg::nibble_t   ad9866_rx;
  logic                  ad9866_rxsync;

  integer seed = 32'h155f04b2;

  // Codec RX model state
  logic                rx_second = 1'b0;
  ad9866_pkg::sample_t codec_word = '0;

  // Reference model state, {pga5, txsync, nibble} per TX edge
  logic [7:0]          tx_q[$];
  logic                m_phase = 1'b0;
  logic                m_tx_en_d1 = 1'b0;
  logic [5:0]          m_rx_gain = 6'h00;
  logic [5:0]          m_tx_gain = 6'h00;
  logic                m_tx_gain_en = 1'b0;
  logic [5:0]          m_gain = 6'h00;
  logic                m_update = 1'b0;
  logic                m_ack = 1'b0;
  logic [5:0]          exp_tx = 6'h00;
  logic                exp_txsync = 1'b0;
  logic                exp_pga5 = 1'b0;
  logic [5:0]          m_prev_nib = 6'h00;
  logic                m_p1_valid = 1'b0;
  logic                m_p2_valid = 1'b0;
  logic [11:0]         m_p1_word = '0;
  logic [11:0]         m_p2_word = '0;
  logic                exp_rx_strobe = 1'b0;
  logic [11:0]         exp_rx_data = '0;
  logic                exp_clip = 1'b0;
  logic                exp_good = 1'b0;
  int                  gain_frames = 0;
  int                  cw_zero_hits = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ad9866_port i_dut (.*);

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Gain code from a 7-bit command field
  function automatic logic [5:0] expected_gain(input logic [6:0] field);
    logic [5:0] g;
    case (field[6:5])
      2'b10, 2'b11: g = field[5:0];
      2'b01:        g = field[5:0] ^ 6'h3f;
      default:      g = {1'b1, field[4:0]};
    endcase
    return g;
  endfunction

  // Advance the model by one clock edge, from the inputs seen at that edge
  task automatic model_step();
    logic       active;
    logic       taken;
    logic [5:0] g_next;
    logic [7:0] tx_cur;
    logic [7:0] hi;
    logic [7:0] lo;
    if (rxclrstatus) begin
      tx_q.delete();
      m_phase       = 1'b0;
      m_tx_en_d1    = 1'b0;
      m_rx_gain     = ad9866_pkg::GAIN_RX_RESET;
      m_tx_gain     = '0;
      m_tx_gain_en  = 1'b0;
      m_gain        = '0;
      m_update      = 1'b0;
      m_ack         = 1'b0;
      {exp_pga5, exp_txsync, exp_tx} = 8'h00;
      m_p1_valid    = 1'b0;
      m_p2_valid    = 1'b0;
      exp_rx_strobe = 1'b0;
      exp_clip      = 1'b0;
      exp_good      = 1'b0;
    end else begin
      tx_cur = (tx_q.size() > 0) ? tx_q.pop_front() : 8'h00;
      {exp_pga5, exp_txsync, exp_tx} = tx_cur;
      // Load edge starts a new frame
      if (m_phase) begin
        if (m_update) begin
          hi = {2'b10, m_gain};
          gain_frames++;
        end else begin
          hi = m_tx_en_d1 ? {2'b00, tx_data[11:6]} : 8'h00;
        end
        lo = m_tx_en_d1 ? {1'b0, !m_update, tx_data[5:0]} : 8'h00;
        tx_q.push_back(hi);
        tx_q.push_back(lo);
      end
      active = tx_en && m_tx_gain_en;
      taken  = m_phase && m_update;
      g_next = m_gain;
      if ((m_rx_gain != m_gain) && !active) begin
        g_next = m_rx_gain;
      end else if ((m_tx_gain != m_gain) && active) begin
        g_next = m_tx_gain;
      end else if ((m_tx_gain != m_gain) && cw_on) begin
        g_next = '0;
        cw_zero_hits++;
      end
      m_update = (g_next != m_gain) || (m_update && !taken);
      m_gain   = g_next;
      m_ack    = cmd_rqst;
      if (cmd_rqst && (cmd_addr == ad9866_pkg::ADDR_RX_GAIN)) begin
        m_rx_gain = expected_gain(cmd_data[6:0]);
      end
      if (cmd_rqst && (cmd_addr == ad9866_pkg::ADDR_TX_GAIN)) begin
        m_tx_gain    = expected_gain(cmd_data[14:8]);
        m_tx_gain_en = cmd_data[15];
      end
      // Flags see the word on the strobe before this edge
      if (exp_rx_strobe && ((exp_rx_data == ad9866_pkg::CLIP_POS) ||
                            (exp_rx_data == ad9866_pkg::CLIP_NEG))) begin
        exp_clip = 1'b1;
      end
      if (exp_rx_strobe && ((exp_rx_data[11:9] == ad9866_pkg::GOOD_POS) ||
                            (exp_rx_data[11:9] == ad9866_pkg::GOOD_NEG))) begin
        exp_good = 1'b1;
      end
      exp_rx_strobe = m_p2_valid;
      if (m_p2_valid) begin
        exp_rx_data = m_p2_word;
      end
      m_p2_valid = m_p1_valid;
      m_p2_word  = m_p1_word;
      m_p1_valid = ad9866_rxsync;
      m_p1_word  = {m_prev_nib, ad9866_rx};
      m_phase    = !m_phase;
      m_tx_en_d1 = tx_en;
    end
    m_prev_nib = ad9866_rx;
  endtask

  task automatic drive_inputs(input int mode);
    logic [31:0] r;
    logic [31:0] pick;
    logic        en_next;
    r = $random(seed);
    rxclrstatus <= (mode == MODE_RESET);
    tx_data     <= $random(seed);
    en_next = tx_en;
    case (mode)
      MODE_FRAME:  en_next = 1'b1;
      MODE_GAIN:   en_next = (r[3:0] != 4'd0);
      MODE_SELECT: en_next = (r[4:0] == 5'd0) ? !tx_en : tx_en;
      default:     en_next = tx_en;
    endcase
    tx_en <= en_next;
    cw_on <= (mode == MODE_SELECT) && !en_next && (r[6:5] == 2'b00);
    // Single cycle command requests with a gap between them
    if (!cmd_rqst && (mode >= MODE_GAIN) && (r[9:7] == 3'd0)) begin
      cmd_rqst <= 1'b1;
      case (r[11:10])
        2'd0:    cmd_addr <= ad9866_pkg::ADDR_RX_GAIN;
        2'd3:    cmd_addr <= r[29:24];
        default: cmd_addr <= ad9866_pkg::ADDR_TX_GAIN;
      endcase
      cmd_data <= $random(seed);
    end else begin
      cmd_rqst <= 1'b0;
    end
    // Codec sends the high nibble, then the low nibble with rxsync
    if (rx_second) begin
      ad9866_rx     <= codec_word[5:0];
      ad9866_rxsync <= 1'b1;
      rx_second = 1'b0;
    end else if (r[14:12] == 3'd0) begin
      ad9866_rx     <= r[20:15];
      ad9866_rxsync <= 1'b0;
    end else begin
      pick = $random(seed);
      case (pick[3:0])
        4'd0:    codec_word = ad9866_pkg::CLIP_POS;
        4'd1:    codec_word = ad9866_pkg::CLIP_NEG;
        4'd2:    codec_word = {ad9866_pkg::GOOD_POS, pick[12:4]};
        4'd3:    codec_word = {ad9866_pkg::GOOD_NEG, pick[12:4]};
        default: codec_word = pick[27:16];
      endcase
      ad9866_rx     <= codec_word[11:6];
      ad9866_rxsync <= 1'b0;
      rx_second = 1'b1;
    end
  endtask

  task automatic compare_outputs();
    expect_equal(tx_strobe, m_phase & m_tx_en_d1, "tx_strobe");
    expect_equal(ad9866_txquiet_n, m_tx_en_d1, "ad9866_txquiet_n");
    expect_equal(ad9866_tx, exp_tx, "ad9866_tx");
    expect_equal(ad9866_txsync, exp_txsync, "ad9866_txsync");
    expect_equal(ad9866_pga5, exp_pga5, "ad9866_pga5");
    expect_equal(ad9866_mode, 1'b1, "ad9866_mode");
    expect_equal(cmd_ack, m_ack, "cmd_ack");
    expect_equal(rx_strobe, exp_rx_strobe, "rx_strobe");
    if (exp_rx_strobe) begin
      expect_equal(rx_data, exp_rx_data, "rx_data");
    end
    expect_equal(rxclip, exp_clip, "rxclip");
    expect_equal(rxgoodlvl, exp_good, "rxgoodlvl");
  endtask

  task automatic run_cycles(input int n, input int mode);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      model_step();
      drive_inputs(mode);
      @(negedge clk);
      compare_outputs();
    end
  endtask

  initial begin
    rxclrstatus   = 1'b1;
    tx_data       = '0;
    tx_en         = 1'b0;
    cw_on         = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_rqst      = 1'b0;
    ad9866_rx     = '0;
    ad9866_rxsync = 1'b0;
    // Reset is already high at the first edge
    run_cycles(RESET_CYCLES - 1, MODE_RESET);
    run_cycles(FRAME_CYCLES, MODE_FRAME);
    run_cycles(GAIN_CYCLES, MODE_GAIN);
    run_cycles(SELECT_CYCLES, MODE_SELECT);
    expect_equal({rxclip, rxgoodlvl}, 2'b11, "status flags before reset");
    run_cycles(MID_RESET_CYCLES, MODE_RESET);
    expect_equal({rxclip, rxgoodlvl}, 2'b00, "status flags after reset");
    run_cycles(TAIL_CYCLES, MODE_SELECT);
    expect_equal(gain_frames > 0, 1'b1, "gain frames seen");
    expect_equal(cw_zero_hits > 0, 1'b1, "cw zero gain selections");
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the test sequence finished", TIMEOUT_NS);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

`default_nettype wire

// File: ad9866_port.f
verilog/ad9866_pkg.sv
verilog/gain_control.sv
verilog/tx_serializer.sv
verilog/rx_deserializer.sv
verilog/level_monitor.sv
verilog/ad9866_port.sv
bench/tb_ad9866_port.sv

// File: Bender.yml
package:
  name: ad9866_port

sources:
  # Package first, then the blocks, then the top level
  - verilog/ad9866_pkg.sv
  - verilog/gain_control.sv
  - verilog/tx_serializer.sv
  - verilog/rx_deserializer.sv
  - verilog/level_monitor.sv
  - verilog/ad9866_port.sv

  - target: test
    files:
      - bench/tb_ad9866_port.sv
